// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_results_accel
FILELIST  ?= list.f
OBJDIR    ?= obj_dir
PASS_MSG  := Everything OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass line"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

// File: list.f
src/results_pkg.sv
src/lane_best_tracker.sv
src/batch_controller.sv
src/result_merger.sv
src/result_serializer.sv
src/stream_fifo.sv
src/results_accel.sv
test/tb_results_accel.sv

// File: src/batch_controller.sv
`timescale 1ns/1ps
`default_nettype none

module batch_controller (
    input  wire                            clk,
    input  wire                            rst,
    input  wire [results_pkg::WORD_W-1:0]  i_seg_cnt [results_pkg::NUM_LANES],
    input  wire [results_pkg::WORD_W-1:0]  i_seg_target [results_pkg::NUM_LANES],
    input  wire                            i_tx_results,
    output logic                           o_batch_done,
    output logic                           o_tx_start
);

    logic result_ready;
    logic tx_req;
    logic fire;

    // All lanes reached their segment target
    always_comb begin
        o_batch_done = 1'b1;
        for (int i = 0; i < results_pkg::NUM_LANES; i++) begin
            if (i_seg_cnt[i] != i_seg_target[i]) begin
                o_batch_done = 1'b0;
            end
        end
    end

    assign fire = result_ready && tx_req;

    //////////////////////////////
    // Transmit latches
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            result_ready <= 1'b0;
            tx_req       <= 1'b0;
            o_tx_start   <= 1'b0;
        end else begin
            result_ready <= (result_ready && !fire) || o_batch_done;
            tx_req       <= (tx_req && !fire) || i_tx_results;
            o_tx_start   <= fire;
        end
    end

endmodule

`default_nettype wire

// File: src/lane_best_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module lane_best_tracker (
    input  wire                            clk,
    input  wire                            rst,
    input  wire results_pkg::lane_in_t     i_lane,
    input  wire                            i_clear,
    output results_pkg::batch_t            o_records,
    output logic [results_pkg::WORD_W-1:0] o_seg_cnt
);

    logic [results_pkg::SLOT_IDX_W-1:0] slot_cnt;
    logic                               first_pass_done;
    logic                               last_slot;
    logic                               take;

    assign last_slot = (slot_cnt ==
                        results_pkg::SLOT_IDX_W'(results_pkg::SLOTS_PER_BATCH - 1));

    // First pass stores unconditionally, later passes keep the strict minimum
    assign take = i_clear || !first_pass_done ||
                  (i_lane.rec.min_val < o_records[slot_cnt].min_val);

    //////////////////////////////
    // Slot counter
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            slot_cnt <= '0;
        end else if (i_lane.valid) begin
            if (last_slot) begin
                slot_cnt <= '0;
            end else begin
                slot_cnt <= slot_cnt + 1'b1;
            end
        end
    end

    //////////////////////////////
    // Best records per slot
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            o_records       <= '0;
            first_pass_done <= 1'b0;
            o_seg_cnt       <= '0;
        end else begin
            // Batch done empties the lane for the next batch
            if (i_clear) begin
                o_records       <= '0;
                first_pass_done <= 1'b0;
                o_seg_cnt       <= '0;
            end
            if (i_lane.valid) begin
                if (take) begin
                    o_records[slot_cnt] <= i_lane.rec;
                end
                // One reference segment done
                if (last_slot) begin
                    first_pass_done <= 1'b1;
                    if (i_clear) begin
                        o_seg_cnt <= results_pkg::WORD_W'(1);
                    end else begin
                        o_seg_cnt <= o_seg_cnt + 1'b1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: src/result_merger.sv
`timescale 1ns/1ps
`default_nettype none

module result_merger (
    input  wire                        clk,
    input  wire                        rst,
    input  wire results_pkg::batch_t   i_lane_records [results_pkg::NUM_LANES],
    input  wire                        i_capture,
    output results_pkg::batch_t        o_batch
);

    results_pkg::batch_t merged;

    //////////////////////////////
    // Per-slot minimum
    //////////////////////////////

    // Ties go to lane 1
    always_comb begin
        for (int s = 0; s < results_pkg::SLOTS_PER_BATCH; s++) begin
            if (i_lane_records[0][s].min_val < i_lane_records[1][s].min_val) begin
                merged[s] = i_lane_records[0][s];
            end else begin
                merged[s] = i_lane_records[1][s];
            end
        end
    end

    //////////////////////////////
    // Snapshot
    //////////////////////////////

    // Trackers clear on the same edge, so this takes the old values
    always_ff @(posedge clk) begin
        if (rst) begin
            o_batch <= '0;
        end else if (i_capture) begin
            o_batch <= merged;
        end
    end

endmodule

`default_nettype wire

// File: src/result_serializer.sv
`timescale 1ns/1ps
`default_nettype none

module result_serializer (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        i_start,
    input  wire results_pkg::batch_t   i_batch,
    input  wire                        i_fifo_full,
    output logic                       o_wr_en,
    output results_pkg::beat_t         o_wr_beat
);

    results_pkg::ser_state_t                state;
    logic [results_pkg::WORD_IDX_W-1:0]     word_idx;
    logic [results_pkg::SLOT_IDX_W-1:0]     slot_sel;
    logic                                   last_word;
    results_pkg::match_rec_t                cur_rec;

    assign slot_sel  = results_pkg::SLOT_IDX_W'(word_idx / results_pkg::WORDS_PER_REC);
    assign cur_rec   = i_batch[slot_sel];
    assign last_word = (word_idx ==
                        results_pkg::WORD_IDX_W'(results_pkg::WORDS_PER_BATCH - 1));

    // Word select within the current record
    always_comb begin
        case (word_idx % results_pkg::WORDS_PER_REC)
            0:       o_wr_beat.data = cur_rec.query_id;
            1:       o_wr_beat.data = cur_rec.ref_id;
            2:       o_wr_beat.data = cur_rec.min_val;
            default: o_wr_beat.data = cur_rec.position;
        endcase
        o_wr_beat.last = last_word;
    end

    assign o_wr_en = (state == results_pkg::SER_SEND) && !i_fifo_full;

    //////////////////////////////
    // FSM
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= results_pkg::SER_IDLE;
            word_idx <= '0;
        end else begin
            case (state)
                results_pkg::SER_IDLE: begin
                    if (i_start) begin
                        state    <= results_pkg::SER_SEND;
                        word_idx <= '0;
                    end
                end
                default: begin
                    // Hold the word while the FIFO is full
                    if (!i_fifo_full) begin
                        if (last_word) begin
                            state <= results_pkg::SER_IDLE;
                        end
                        word_idx <= word_idx + 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/results_accel.sv
`timescale 1ns/1ps
`default_nettype none

module results_accel (
    input  wire                            clk,
    input  wire                            rst,
    input  wire results_pkg::lane_in_t     i_lane [results_pkg::NUM_LANES],
    input  wire [results_pkg::WORD_W-1:0]  i_seg_target [results_pkg::NUM_LANES],
    input  wire                            i_tx_results,
    output wire                            o_query_next,
    output wire                            o_tvalid,
    input  wire                            i_tready,
    output wire [results_pkg::WORD_W-1:0]  o_tdata,
    output wire                            o_tlast
);

    results_pkg::batch_t          lane_records [results_pkg::NUM_LANES];
    logic [results_pkg::WORD_W-1:0] seg_cnt [results_pkg::NUM_LANES];
    logic                         batch_done;
    logic                         tx_start;
    results_pkg::batch_t          snapshot;
    logic                         fifo_full;
    logic                         wr_en;
    results_pkg::beat_t           wr_beat;

    assign o_query_next = batch_done;

    //////////////////////////////
    // Lane trackers
    //////////////////////////////

    for (genvar g = 0; g < results_pkg::NUM_LANES; g++) begin : g_lane
        lane_best_tracker tracker_inst (
            .clk       (clk),
            .rst       (rst),
            .i_lane    (i_lane[g]),
            .i_clear   (batch_done),
            .o_records (lane_records[g]),
            .o_seg_cnt (seg_cnt[g])
        );
    end

    batch_controller batch_controller_inst (
        .clk          (clk),
        .rst          (rst),
        .i_seg_cnt    (seg_cnt),
        .i_seg_target (i_seg_target),
        .i_tx_results (i_tx_results),
        .o_batch_done (batch_done),
        .o_tx_start   (tx_start)
    );

    result_merger result_merger_inst (
        .clk            (clk),
        .rst            (rst),
        .i_lane_records (lane_records),
        .i_capture      (batch_done),
        .o_batch        (snapshot)
    );

    //////////////////////////////
    // Output path
    //////////////////////////////

    result_serializer result_serializer_inst (
        .clk         (clk),
        .rst         (rst),
        .i_start     (tx_start),
        .i_batch     (snapshot),
        .i_fifo_full (fifo_full),
        .o_wr_en     (wr_en),
        .o_wr_beat   (wr_beat)
    );

    stream_fifo stream_fifo_inst (
        .clk       (clk),
        .rst       (rst),
        .i_wr_en   (wr_en),
        .i_wr_beat (wr_beat),
        .o_full    (fifo_full),
        .o_tvalid  (o_tvalid),
        .o_tdata   (o_tdata),
        .o_tlast   (o_tlast),
        .i_tready  (i_tready)
    );

endmodule

`default_nettype wire

// File: src/results_pkg.sv
`default_nettype none

package results_pkg;

    //////////////////////////////
    // Sizes
    //////////////////////////////

    localparam int NUM_LANES       = 2;
    localparam int SLOTS_PER_BATCH = 8;
    localparam int SLOT_IDX_W      = 3;
    localparam int WORD_W          = 32;
    localparam int WORDS_PER_REC   = 4;
    localparam int WORDS_PER_BATCH = SLOTS_PER_BATCH * WORDS_PER_REC;
    localparam int WORD_IDX_W      = 5;
    localparam int FIFO_DEPTH      = 4;

    //////////////////////////////
    // Records and beats
    //////////////////////////////

    // Field order is also the output word order
    typedef struct packed {
        logic [WORD_W-1:0] query_id;
        logic [WORD_W-1:0] ref_id;
        logic [WORD_W-1:0] min_val;
        logic [WORD_W-1:0] position;
    } match_rec_t;

    typedef struct packed {
        logic       valid;
        match_rec_t rec;
    } lane_in_t;

    typedef match_rec_t [SLOTS_PER_BATCH-1:0] batch_t;

    typedef struct packed {
        logic [WORD_W-1:0] data;
        logic              last;
    } beat_t;

    typedef enum logic {
        SER_IDLE,
        SER_SEND
    } ser_state_t;

endpackage

`default_nettype wire

// File: src/stream_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module stream_fifo (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            i_wr_en,
    input  wire results_pkg::beat_t        i_wr_beat,
    output logic                           o_full,
    output logic                           o_tvalid,
    output logic [results_pkg::WORD_W-1:0] o_tdata,
    output logic                           o_tlast,
    input  wire                            i_tready
);

    results_pkg::beat_t mem [results_pkg::FIFO_DEPTH];

    logic [$clog2(results_pkg::FIFO_DEPTH)-1:0]   wr_ptr;
    logic [$clog2(results_pkg::FIFO_DEPTH)-1:0]   rd_ptr;
    logic [$clog2(results_pkg::FIFO_DEPTH+1)-1:0] count;
    logic                                         push;
    logic                                         pop;

    assign o_full   = (32'(count) == results_pkg::FIFO_DEPTH);
    assign o_tvalid = (count != '0);

    // Head beat is visible before it is taken
    assign o_tdata = mem[rd_ptr].data;
    assign o_tlast = mem[rd_ptr].last;

    assign push = i_wr_en && !o_full;
    assign pop  = o_tvalid && i_tready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= i_wr_beat;
        end
    end

    //////////////////////////////
    // Pointers and count
    //////////////////////////////

    // Depth is a power of two, pointers wrap on their own
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: test/tb_results_accel.sv
`timescale 1ns/1ps
`default_nettype none

module tb_results_accel;

    localparam int CLK_PERIOD      = 10;
    localparam int NUM_BATCHES     = 3;
    localparam int TOTAL_BEATS     = NUM_BATCHES * results_pkg::WORDS_PER_BATCH;
    localparam int CYCLES_PER_BEAT = 20;

    logic                           clk;
    logic                           rst;
    results_pkg::lane_in_t          lane_in [results_pkg::NUM_LANES];
    logic [results_pkg::WORD_W-1:0] seg_target [results_pkg::NUM_LANES];
    logic                           tx_results;
    logic                           query_next;
    logic                           tvalid;
    logic                           tready;
    logic                           stall;
    logic [results_pkg::WORD_W-1:0] tdata;
    logic                           tlast;

    integer seed       = 32'hd0fa_e4e6;
    int     val_errs   = 0;
    int     other_errs = 0;
    int     qn_pulses  = 0;
    int     batch_no   = 0;

    results_pkg::match_rec_t ref_best [results_pkg::NUM_LANES][results_pkg::SLOTS_PER_BATCH];
    logic                    ref_first [results_pkg::NUM_LANES];
    results_pkg::beat_t      exp_q [$];
    results_pkg::beat_t      exp_beat;

    results_accel results_accel_inst (
        .clk          (clk),
        .rst          (rst),
        .i_lane       (lane_in),
        .i_seg_target (seg_target),
        .i_tx_results (tx_results),
        .o_query_next (query_next),
        .o_tvalid     (tvalid),
        .i_tready     (tready),
        .o_tdata      (tdata),
        .o_tlast      (tlast)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Roughly one stall in four
    always begin
        @(posedge clk);
        stall = (($random(seed) & 3) == 0);
        #1;
        tready = !stall;
    end

    //////////////////////////////
    // Stream checks
    //////////////////////////////

    assert property (@(posedge clk) disable iff (rst)
        (tvalid && !tready) |=> (tvalid && $stable(tdata) && $stable(tlast)))
    else begin
        val_errs++;
        $display("ERR @%0t: stream head changed while stalled", $time);
    end

    always @(negedge clk) begin
        if (!rst && tvalid && tready) begin
            if (exp_q.size() == 0) begin
                other_errs++;
                $display("Beat accepted at %0t with no result pending", $time);
            end else begin
                exp_beat = exp_q.pop_front();
                assert (tdata == exp_beat.data && tlast == exp_beat.last)
                else begin
                    val_errs++;
                    $display("ERR @%0t: beat %h last %b, expected %h last %b", $time,
                             tdata, tlast, exp_beat.data, exp_beat.last);
                end
            end
        end
        if (!rst && query_next) begin
            qn_pulses++;
        end
    end

    //////////////////////////////
    // Tasks
    //////////////////////////////

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    // Strict minimum per slot, first pass always stored
    task automatic model_record(input int l, input int s, input results_pkg::match_rec_t rec);
        if (!ref_first[l] || rec.min_val < ref_best[l][s].min_val) begin
            ref_best[l][s] = rec;
        end
        if (s == results_pkg::SLOTS_PER_BATCH - 1) begin
            ref_first[l] = 1'b1;
        end
    endtask

    task automatic push_expected();
        results_pkg::match_rec_t win;
        results_pkg::beat_t      b;
        int                      idx;
        idx = 0;
        for (int s = 0; s < results_pkg::SLOTS_PER_BATCH; s++) begin
            // Equal distances go to lane 1
            win = (ref_best[0][s].min_val < ref_best[1][s].min_val) ? ref_best[0][s]
                                                                    : ref_best[1][s];
            for (int w = 0; w < results_pkg::WORDS_PER_REC; w++) begin
                case (w)
                    0:       b.data = win.query_id;
                    1:       b.data = win.ref_id;
                    2:       b.data = win.min_val;
                    default: b.data = win.position;
                endcase
                b.last = (idx == results_pkg::WORDS_PER_BATCH - 1);
                exp_q.push_back(b);
                idx++;
            end
        end
        for (int l = 0; l < results_pkg::NUM_LANES; l++) begin
            ref_first[l] = 1'b0;
            for (int s = 0; s < results_pkg::SLOTS_PER_BATCH; s++) begin
                ref_best[l][s] = '0;
            end
        end
    endtask

    // Mode 0 fixed ties and wins, 1 small random, 2 above any earlier value
    task automatic run_batch(input int tgt0, input int tgt1, input int mode);
        int                      tgt [results_pkg::NUM_LANES];
        int                      nseg;
        results_pkg::match_rec_t rec;
        tgt[0] = tgt0;
        tgt[1] = tgt1;
        nseg = (tgt0 > tgt1) ? tgt0 : tgt1;
        seg_target[0] = 32'(tgt0);
        seg_target[1] = 32'(tgt1);
        step();
        for (int seg = 0; seg < nseg; seg++) begin
            for (int s = 0; s < results_pkg::SLOTS_PER_BATCH; s++) begin
                assert (!query_next) else begin
                    val_errs++;
                    $display("ERR @%0t: query_next high before the batch ended", $time);
                end
                for (int l = 0; l < results_pkg::NUM_LANES; l++) begin
                    lane_in[l].valid = 1'b0;
                    if (seg < tgt[l]) begin
                        rec.query_id = 32'(batch_no * 16 + s);
                        rec.ref_id   = 32'(l * 256 + seg);
                        rec.position = $random(seed);
                        case (mode)
                            0: rec.min_val = (s % 3 == 0) ? 32'd40 :
                                             ((l == s % 2) ? 32'd10 : 32'd30);
                            1: rec.min_val = 32'($random(seed) & 15);
                            default: rec.min_val = 32'h1000 + 32'($random(seed) & 255);
                        endcase
                        lane_in[l].valid = 1'b1;
                        lane_in[l].rec   = rec;
                        model_record(l, s, rec);
                    end
                end
                step();
            end
        end
        lane_in[0].valid = 1'b0;
        lane_in[1].valid = 1'b0;
        assert (query_next) else begin
            val_errs++;
            $display("ERR @%0t: query_next low after the final record", $time);
        end
        push_expected();
        step();
        assert (!query_next) else begin
            val_errs++;
            $display("ERR @%0t: query_next longer than one cycle", $time);
        end
        batch_no++;
    endtask

    task automatic request_tx();
        tx_results = 1'b1;
        step();
        tx_results = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            step();
        end
    endtask

    task automatic expect_idle(input int cycles);
        repeat (cycles) begin
            assert (!tvalid) else begin
                other_errs++;
                $display("Stream active at %0t while no transfer was due", $time);
            end
            step();
        end
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        tx_results = 1'b0;
        tready     = 1'b0;
        for (int l = 0; l < results_pkg::NUM_LANES; l++) begin
            lane_in[l]    = '0;
            seg_target[l] = 32'd1;
            ref_first[l]  = 1'b0;
            for (int s = 0; s < results_pkg::SLOTS_PER_BATCH; s++) begin
                ref_best[l][s] = '0;
            end
        end
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        // Quiet after reset
        repeat (10) begin
            assert (!tvalid && !query_next) else begin
                other_errs++;
                $display("Output active after reset with no lane input");
            end
            step();
        end

        // Request ahead of completion, one segment per lane
        request_tx();
        run_batch(1, 1, 0);
        wait_drain();
        expect_idle(40);

        // Several segments, request after completion
        run_batch(3, 2, 1);
        request_tx();
        wait_drain();
        expect_idle(20);

        // Cleared records, then nothing leaves until requested
        run_batch(1, 1, 2);
        expect_idle(100);
        request_tx();
        wait_drain();
        expect_idle(20);

        assert (qn_pulses == NUM_BATCHES) else begin
            val_errs++;
            $display("ERR @%0t: %0d query_next pulses for %0d batches", $time,
                     qn_pulses, NUM_BATCHES);
        end
        $display("Errors: %0d value, %0d other", val_errs, other_errs);
        if (val_errs == 0 && other_errs == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        #(TOTAL_BEATS * CYCLES_PER_BEAT * CLK_PERIOD);
        $display("Watchdog expired at %0t before all results were streamed", $time);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire
